/* Makefile */
# Verilator build for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_id_stage
FLIST     ?= flist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FLIST) $(wildcard logic/*.sv logic/*.svh sim/*.sv)
	$(VERILATOR) --binary --timing -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
+incdir+logic
logic/id_pkg.sv
logic/rf_read_if.sv
logic/regfile.sv
logic/id_pipe_reg.sv
logic/inst_decoder.sv
logic/operand_bypass.sv
logic/branch_unit.sv
logic/id_stage.sv
sim/tb_id_stage.sv

/* logic/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  id_pkg::dec_ctrl_t  ctrl,
    input  logic               id_valid,
    input  id_pkg::word_t      id_pc,
    input  id_pkg::word_t      rj_value,
    input  id_pkg::word_t      rkd_value,
    input  logic               stall,
    output logic               br_taken,
    output id_pkg::word_t      br_target,
    output logic               br_stall
);
    import id_pkg::*;

    logic rj_eq_rd;
    logic rj_lt_rd;
    logic rj_ltu_rd;
    logic cond;

    assign rj_eq_rd  = rj_value == rkd_value;
    assign rj_lt_rd  = $signed(rj_value) < $signed(rkd_value);
    assign rj_ltu_rd = rj_value < rkd_value;

    always_comb begin
        case (ctrl.br_kind)
            BR_BEQ:                cond = rj_eq_rd;
            BR_BNE:                cond = !rj_eq_rd;
            BR_BLT:                cond = rj_lt_rd;
            BR_BGE:                cond = !rj_lt_rd;
            BR_BLTU:               cond = rj_ltu_rd;
            BR_BGEU:               cond = !rj_ltu_rd;
            BR_B, BR_BL, BR_JIRL:  cond = 1'b1;    // unconditional
            default:               cond = 1'b0;
        endcase
    end

    // compare is only trusted once the operands are final
    assign br_taken  = id_valid & ~stall & cond;
    assign br_target = (ctrl.br_kind == BR_JIRL) ? rj_value + ctrl.br_offs
                                                 : id_pc + ctrl.br_offs;
    assign br_stall  = id_valid & stall & (ctrl.br_kind != BR_NONE);

endmodule

/* logic/id_config.svh */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// data path and address width of the core
`define ID_XLEN       32

// register file geometry
`define ID_RADDR_W    5
`define ID_NUM_REGS   32

// one bit per alu operation, one-hot
`define ID_ALU_OP_W   12

`endif

/* logic/id_pipe_reg.sv */
`timescale 1ns/1ps

module id_pipe_reg (
    input  logic           clk,
    input  logic           resetn,
    input  logic           fetch_valid,
    input  id_pkg::word_t  fetch_inst,
    input  id_pkg::word_t  fetch_pc,
    input  logic           ex_allowin,
    input  logic           stall,
    input  logic           br_taken,
    output logic           id_valid,
    output id_pkg::word_t  id_inst,
    output id_pkg::word_t  id_pc,
    output logic           id_allowin,
    output logic           issue_valid
);

    logic ready_go;

    assign ready_go    = ~stall;
    // a taken branch drops whatever fetch offers this cycle
    assign id_allowin  = ~id_valid | (ready_go & ex_allowin) | br_taken;
    assign issue_valid = id_valid & ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            id_valid <= 1'b0;
        end else if (br_taken) begin
            id_valid <= 1'b0;              // wrong-path slot
        end else if (id_allowin) begin
            id_valid <= fetch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_valid && id_allowin) begin
            id_inst <= fetch_inst;
            id_pc   <= fetch_pc;
        end
    end

endmodule

/* logic/id_pkg.sv */
`include "id_config.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]     word_t;
    typedef logic [`ID_RADDR_W-1:0]  reg_addr_t;
    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;

    // bit positions inside alu_op_t
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_kind_t;

    typedef struct packed {
        alu_op_t   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        word_t     imm;
        reg_addr_t raddr1;     // always rj
        reg_addr_t raddr2;     // rd or rk
        logic      need_r1;
        logic      need_r2;
        logic      rf_we;
        reg_addr_t dest;
        logic      is_load;
        logic      is_store;
        br_kind_t  br_kind;
        word_t     br_offs;    // already shifted by 2
    } dec_ctrl_t;

endpackage

/* logic/id_stage.sv */
`timescale 1ns/1ps

module id_stage (
    input  logic               clk,
    input  logic               resetn,
    input  logic               fetch_valid,
    input  id_pkg::word_t      fetch_inst,
    input  id_pkg::word_t      fetch_pc,
    input  logic               ex_allowin,
    input  logic               ex_rf_we,
    input  id_pkg::reg_addr_t  ex_rf_waddr,
    input  id_pkg::word_t      ex_rf_wdata,
    input  logic               ex_res_late,
    input  logic               mem_rf_we,
    input  id_pkg::reg_addr_t  mem_rf_waddr,
    input  id_pkg::word_t      mem_rf_wdata,
    input  logic               mem_res_late,
    input  logic               wb_rf_we,
    input  id_pkg::reg_addr_t  wb_rf_waddr,
    input  id_pkg::word_t      wb_rf_wdata,
    output logic               id_allowin,
    output logic               issue_valid,
    output id_pkg::alu_op_t    issue_alu_op,
    output id_pkg::word_t      issue_src1,
    output id_pkg::word_t      issue_src2,
    output id_pkg::word_t      issue_store_data,
    output id_pkg::word_t      issue_pc,
    output logic               issue_rf_we,
    output id_pkg::reg_addr_t  issue_rf_waddr,
    output logic               issue_load,
    output logic               issue_store,
    output logic               br_taken,
    output id_pkg::word_t      br_target,
    output logic               br_stall
);
    import id_pkg::*;

    logic      id_valid;
    word_t     id_inst;
    word_t     id_pc;
    dec_ctrl_t ctrl;
    logic      stall;
    word_t     rj_value;
    word_t     rkd_value;

    rf_read_if rf_bus ();

    id_pipe_reg u_pipe_reg (
        .clk         (clk),
        .resetn      (resetn),
        .fetch_valid (fetch_valid),
        .fetch_inst  (fetch_inst),
        .fetch_pc    (fetch_pc),
        .ex_allowin  (ex_allowin),
        .stall       (stall),
        .br_taken    (br_taken),
        .id_valid    (id_valid),
        .id_inst     (id_inst),
        .id_pc       (id_pc),
        .id_allowin  (id_allowin),
        .issue_valid (issue_valid)
    );

    inst_decoder u_decoder (
        .id_inst (id_inst),
        .ctrl    (ctrl)
    );

    regfile u_regfile (
        .clk   (clk),
        .we    (wb_rf_we),
        .waddr (wb_rf_waddr),
        .wdata (wb_rf_wdata),
        .rf    (rf_bus.rf)
    );

    operand_bypass u_bypass (
        .ctrl         (ctrl),
        .id_pc        (id_pc),
        .ex_rf_we     (ex_rf_we),
        .ex_rf_waddr  (ex_rf_waddr),
        .ex_rf_wdata  (ex_rf_wdata),
        .ex_res_late  (ex_res_late),
        .mem_rf_we    (mem_rf_we),
        .mem_rf_waddr (mem_rf_waddr),
        .mem_rf_wdata (mem_rf_wdata),
        .mem_res_late (mem_res_late),
        .wb_rf_we     (wb_rf_we),
        .wb_rf_waddr  (wb_rf_waddr),
        .wb_rf_wdata  (wb_rf_wdata),
        .rd_port      (rf_bus.reader),
        .rj_value     (rj_value),
        .rkd_value    (rkd_value),
        .src1         (issue_src1),
        .src2         (issue_src2),
        .stall        (stall)
    );

    branch_unit u_branch (
        .ctrl      (ctrl),
        .id_valid  (id_valid),
        .id_pc     (id_pc),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .stall     (stall),
        .br_taken  (br_taken),
        .br_target (br_target),
        .br_stall  (br_stall)
    );

    assign issue_alu_op     = ctrl.alu_op;
    assign issue_store_data = rkd_value;    // st.w reads rd through port 2
    assign issue_pc         = id_pc;
    assign issue_rf_we      = ctrl.rf_we;
    assign issue_rf_waddr   = ctrl.dest;
    assign issue_load       = ctrl.is_load;
    assign issue_store      = ctrl.is_store;

endmodule

/* logic/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder (
    input  id_pkg::word_t     id_inst,
    output id_pkg::dec_ctrl_t ctrl
);
    import id_pkg::*;

    wire [5:0]  op_31_26 = id_inst[31:26];
    wire [3:0]  op_25_22 = id_inst[25:22];
    wire [1:0]  op_21_20 = id_inst[21:20];
    wire [4:0]  op_19_15 = id_inst[19:15];
    wire reg_addr_t rd   = id_inst[4:0];
    wire reg_addr_t rj   = id_inst[9:5];
    wire reg_addr_t rk   = id_inst[14:10];
    wire [11:0] i12      = id_inst[21:10];
    wire [19:0] i20      = id_inst[24:5];
    wire [15:0] i16      = id_inst[25:10];
    wire [25:0] i26      = {id_inst[9:0], id_inst[25:10]};

    // opcode groups shared by several instructions
    wire grp_op0 = op_31_26 == 6'h00;
    wire grp_3r  = grp_op0 && op_25_22 == 4'h0 && op_21_20 == 2'h1;
    wire grp_sh  = grp_op0 && op_25_22 == 4'h1 && op_21_20 == 2'h0;
    wire grp_mem = op_31_26 == 6'h0a;

    wire inst_add_w     = grp_3r && op_19_15 == 5'h00;
    wire inst_sub_w     = grp_3r && op_19_15 == 5'h02;
    wire inst_slt       = grp_3r && op_19_15 == 5'h04;
    wire inst_sltu      = grp_3r && op_19_15 == 5'h05;
    wire inst_nor       = grp_3r && op_19_15 == 5'h08;
    wire inst_and       = grp_3r && op_19_15 == 5'h09;
    wire inst_or        = grp_3r && op_19_15 == 5'h0a;
    wire inst_xor       = grp_3r && op_19_15 == 5'h0b;
    wire inst_sll_w     = grp_3r && op_19_15 == 5'h0e;
    wire inst_srl_w     = grp_3r && op_19_15 == 5'h0f;
    wire inst_sra_w     = grp_3r && op_19_15 == 5'h10;
    wire inst_slli_w    = grp_sh && op_19_15 == 5'h01;
    wire inst_srli_w    = grp_sh && op_19_15 == 5'h09;
    wire inst_srai_w    = grp_sh && op_19_15 == 5'h11;
    wire inst_slti      = grp_op0 && op_25_22 == 4'h8;
    wire inst_sltui     = grp_op0 && op_25_22 == 4'h9;
    wire inst_addi_w    = grp_op0 && op_25_22 == 4'ha;
    wire inst_andi      = grp_op0 && op_25_22 == 4'hd;
    wire inst_ori       = grp_op0 && op_25_22 == 4'he;
    wire inst_xori      = grp_op0 && op_25_22 == 4'hf;
    wire inst_lu12i_w   = op_31_26 == 6'h05 && !id_inst[25];
    wire inst_pcaddu12i = op_31_26 == 6'h07 && !id_inst[25];
    wire inst_ld_w      = grp_mem && op_25_22 == 4'h2;
    wire inst_st_w      = grp_mem && op_25_22 == 4'h6;

    // conditional branches compare rj with rd
    wire inst_cond_br   = op_31_26 >= 6'h16 && op_31_26 <= 6'h1b;
    wire inst_jirl      = op_31_26 == 6'h13;
    wire inst_b         = op_31_26 == 6'h14;
    wire inst_bl        = op_31_26 == 6'h15;

    wire is_shift_imm   = inst_slli_w | inst_srli_w | inst_srai_w;
    wire is_si12        = inst_addi_w | inst_slti | inst_sltui | inst_ld_w | inst_st_w;
    wire is_ui12        = inst_andi | inst_ori | inst_xori;
    wire is_si20        = inst_lu12i_w | inst_pcaddu12i;
    wire is_link        = inst_jirl | inst_bl;    // src2 is the constant 4
    wire is_alu_rr      = grp_3r && (inst_add_w | inst_sub_w | inst_slt | inst_sltu | inst_nor
                          | inst_and | inst_or | inst_xor | inst_sll_w | inst_srl_w | inst_sra_w);
    wire known          = is_alu_rr | is_shift_imm | is_si12 | is_ui12 | is_si20
                          | inst_cond_br | inst_jirl | inst_b | inst_bl;

    always_comb begin
        ctrl = '0;
        ctrl.alu_op[ALU_ADD]  = inst_add_w | inst_addi_w | inst_ld_w | inst_st_w
                                | is_link | inst_pcaddu12i;
        ctrl.alu_op[ALU_SUB]  = inst_sub_w;
        ctrl.alu_op[ALU_SLT]  = inst_slt | inst_slti;
        ctrl.alu_op[ALU_SLTU] = inst_sltu | inst_sltui;
        ctrl.alu_op[ALU_AND]  = inst_and | inst_andi;
        ctrl.alu_op[ALU_NOR]  = inst_nor;
        ctrl.alu_op[ALU_OR]   = inst_or | inst_ori;
        ctrl.alu_op[ALU_XOR]  = inst_xor | inst_xori;
        ctrl.alu_op[ALU_SLL]  = inst_sll_w | inst_slli_w;
        ctrl.alu_op[ALU_SRL]  = inst_srl_w | inst_srli_w;
        ctrl.alu_op[ALU_SRA]  = inst_sra_w | inst_srai_w;
        ctrl.alu_op[ALU_LUI]  = inst_lu12i_w;

        ctrl.src1_is_pc  = inst_pcaddu12i | is_link;
        ctrl.src2_is_imm = is_shift_imm | is_si12 | is_ui12 | is_si20 | is_link;
        if (is_link) begin
            ctrl.imm = 32'd4;
        end else if (is_si20) begin
            ctrl.imm = {i20, 12'b0};
        end else if (is_shift_imm || is_si12) begin
            ctrl.imm = {{20{i12[11]}}, i12};    // ui5 sits in the low bits
        end else begin
            ctrl.imm = {20'b0, i12};
        end

        ctrl.raddr1   = rj;
        ctrl.raddr2   = (inst_st_w || inst_cond_br) ? rd : rk;
        ctrl.need_r1  = known & ~(inst_b | inst_bl | is_si20);
        ctrl.need_r2  = is_alu_rr | inst_st_w | inst_cond_br;
        ctrl.rf_we    = known & ~(inst_st_w | inst_cond_br | inst_b);
        ctrl.dest     = inst_bl ? reg_addr_t'(1) : rd;
        ctrl.is_load  = inst_ld_w;
        ctrl.is_store = inst_st_w;

        case (op_31_26)
            6'h13:   ctrl.br_kind = BR_JIRL;
            6'h14:   ctrl.br_kind = BR_B;
            6'h15:   ctrl.br_kind = BR_BL;
            6'h16:   ctrl.br_kind = BR_BEQ;
            6'h17:   ctrl.br_kind = BR_BNE;
            6'h18:   ctrl.br_kind = BR_BLT;
            6'h19:   ctrl.br_kind = BR_BGE;
            6'h1a:   ctrl.br_kind = BR_BLTU;
            6'h1b:   ctrl.br_kind = BR_BGEU;
            default: ctrl.br_kind = BR_NONE;
        endcase
        ctrl.br_offs = (inst_b || inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                           : {{14{i16[15]}}, i16, 2'b0};
    end

endmodule

/* logic/operand_bypass.sv */
`timescale 1ns/1ps

module operand_bypass (
    input  id_pkg::dec_ctrl_t  ctrl,
    input  id_pkg::word_t      id_pc,
    input  logic               ex_rf_we,
    input  id_pkg::reg_addr_t  ex_rf_waddr,
    input  id_pkg::word_t      ex_rf_wdata,
    input  logic               ex_res_late,
    input  logic               mem_rf_we,
    input  id_pkg::reg_addr_t  mem_rf_waddr,
    input  id_pkg::word_t      mem_rf_wdata,
    input  logic               mem_res_late,
    input  logic               wb_rf_we,
    input  id_pkg::reg_addr_t  wb_rf_waddr,
    input  id_pkg::word_t      wb_rf_wdata,
    rf_read_if.reader          rd_port,
    output id_pkg::word_t      rj_value,
    output id_pkg::word_t      rkd_value,
    output id_pkg::word_t      src1,
    output id_pkg::word_t      src2,
    output logic               stall
);
    import id_pkg::*;

    logic r1_ex, r1_mem, r1_wb;
    logic r2_ex, r2_mem, r2_wb;

    // a needed, nonzero source that an older stage is about to write
    function automatic logic hit(input logic need, input reg_addr_t ra,
                                 input logic we, input reg_addr_t wa);
        return need && ra != '0 && we && ra == wa;
    endfunction

    // youngest producer wins
    function automatic word_t pick(input logic h_ex, input logic h_mem,
                                   input logic h_wb, input word_t rf_data);
        return h_ex  ? ex_rf_wdata  :
               h_mem ? mem_rf_wdata :
               h_wb  ? wb_rf_wdata  : rf_data;
    endfunction

    assign rd_port.raddr1 = ctrl.raddr1;
    assign rd_port.raddr2 = ctrl.raddr2;

    assign r1_ex  = hit(ctrl.need_r1, ctrl.raddr1, ex_rf_we,  ex_rf_waddr);
    assign r1_mem = hit(ctrl.need_r1, ctrl.raddr1, mem_rf_we, mem_rf_waddr);
    assign r1_wb  = hit(ctrl.need_r1, ctrl.raddr1, wb_rf_we,  wb_rf_waddr);
    assign r2_ex  = hit(ctrl.need_r2, ctrl.raddr2, ex_rf_we,  ex_rf_waddr);
    assign r2_mem = hit(ctrl.need_r2, ctrl.raddr2, mem_rf_we, mem_rf_waddr);
    assign r2_wb  = hit(ctrl.need_r2, ctrl.raddr2, wb_rf_we,  wb_rf_waddr);

    // result not produced yet, e.g. load data still in flight
    assign stall = (ex_res_late  & (r1_ex  | r2_ex))
                 | (mem_res_late & (r1_mem | r2_mem));

    assign rj_value  = pick(r1_ex, r1_mem, r1_wb, rd_port.rdata1);
    assign rkd_value = pick(r2_ex, r2_mem, r2_wb, rd_port.rdata2);

    assign src1 = ctrl.src1_is_pc  ? id_pc    : rj_value;
    assign src2 = ctrl.src2_is_imm ? ctrl.imm : rkd_value;

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ps
`include "id_config.svh"

module regfile (
    input  logic                   clk,
    input  logic                   we,
    input  logic [`ID_RADDR_W-1:0] waddr,
    input  logic [`ID_XLEN-1:0]    wdata,
    rf_read_if.rf                  rf
);

    logic [`ID_XLEN-1:0] regs [0:`ID_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;    // r0 is never written
        end
    end

    // r0 is hardwired to zero
    assign rf.rdata1 = (rf.raddr1 == '0) ? '0 : regs[rf.raddr1];
    assign rf.rdata2 = (rf.raddr2 == '0) ? '0 : regs[rf.raddr2];

endmodule

/* logic/rf_read_if.sv */
`timescale 1ns/1ps

// two combinational read ports of the register file
interface rf_read_if;
    import id_pkg::*;

    reg_addr_t raddr1;
    reg_addr_t raddr2;
    word_t     rdata1;
    word_t     rdata2;

    modport reader (
        output raddr1,
        output raddr2,
        input  rdata1,
        input  rdata2
    );

    modport rf (
        input  raddr1,
        input  raddr2,
        output rdata1,
        output rdata2
    );

endinterface

/* sim/tb_id_stage.sv */
`timescale 1ns/1ps

module tb_id_stage;
    import id_pkg::*;

    // register fill 31, alu 22, ld/st 4, branches 18, squash 2, forwarding 3, stalls 2, bp 2
    localparam int NUM_INST  = 84;
    localparam int MAX_CYCLE = NUM_INST * 4 + 100;

    typedef struct packed {
        alu_op_t   op;
        word_t     s1, s2, sd, tg;
        logic      we, ld, st, tk;
        reg_addr_t wa;
    } exp_t;

    logic clk, resetn, fetch_valid, ex_allowin;
    word_t fetch_inst, fetch_pc;
    logic ex_rf_we, ex_res_late, mem_rf_we, mem_res_late, wb_rf_we;
    reg_addr_t ex_rf_waddr, mem_rf_waddr, wb_rf_waddr;
    word_t ex_rf_wdata, mem_rf_wdata, wb_rf_wdata;
    logic id_allowin, issue_valid, issue_rf_we, issue_load, issue_store;
    logic br_taken, br_stall;
    alu_op_t issue_alu_op;
    word_t issue_src1, issue_src2, issue_store_data, issue_pc, br_target;
    reg_addr_t issue_rf_waddr;

    word_t mreg [0:31];    // model of the architectural registers
    word_t inst_q[$];
    word_t pc_q[$];
    word_t rng_state = 32'd17;
    int    mismatches = 0;
    int    other_errs = 0;
    int    cycles = 0;

    id_stage UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLE) begin
            $display("Error: timeout after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    function word_t rnd();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function reg_addr_t rreg();
        word_t t;
        t = rnd();
        return t[4:0];
    endfunction

    function automatic word_t rf_val(input reg_addr_t a);
        return (a == '0) ? '0 : mreg[a];
    endfunction

    // forwarded value, youngest writing stage first
    function automatic word_t fwd_val(input reg_addr_t a);
        if (a == '0) return '0;
        if (ex_rf_we && ex_rf_waddr == a) return ex_rf_wdata;
        if (mem_rf_we && mem_rf_waddr == a) return mem_rf_wdata;
        if (wb_rf_we && wb_rf_waddr == a) return wb_rf_wdata;
        return mreg[a];
    endfunction

    function automatic exp_t expect_issue(input word_t inst, input word_t pc);
        exp_t e;
        reg_addr_t rd, rj, rk, r2;
        word_t v1, v2, imm, offs;
        int op;
        logic n1, n2, ui, pc1;
        logic [5:0] o6;
        o6 = inst[31:26];
        rd = inst[4:0];
        rj = inst[9:5];
        rk = inst[14:10];
        r2 = rk;
        op = -1;
        n1 = 1'b1;
        n2 = 1'b0;
        ui = 1'b0;
        pc1 = 1'b0;
        imm = {{20{inst[21]}}, inst[21:10]};
        offs = {{14{inst[25]}}, inst[25:10], 2'b0};
        e = '0;
        e.we = 1'b1;
        e.wa = rd;
        case (o6)
            6'h00: begin
                if (inst[25:20] == 6'h01) begin       // three-register group
                    n2 = 1'b1;
                    case (inst[19:15])
                        5'h00: op = 0;
                        5'h02: op = 1;
                        5'h04: op = 2;
                        5'h05: op = 3;
                        5'h08: op = 5;
                        5'h09: op = 4;
                        5'h0a: op = 6;
                        5'h0b: op = 7;
                        5'h0e: op = 8;
                        5'h0f: op = 9;
                        default: op = 10;
                    endcase
                end else if (inst[25:20] == 6'h04) begin
                    ui = 1'b1;
                    op = (inst[19:15] == 5'h01) ? 8 : (inst[19:15] == 5'h09) ? 9 : 10;
                end else begin
                    ui = 1'b1;
                    case (inst[25:22])
                        4'h8: op = 2;
                        4'h9: op = 3;
                        4'ha: op = 0;
                        4'hd: op = 4;
                        4'he: op = 6;
                        default: op = 7;
                    endcase
                    if (inst[25:22] >= 4'hd) imm = {20'b0, inst[21:10]};
                end
            end
            6'h05, 6'h07: begin
                op = (o6 == 6'h05) ? 11 : 0;
                ui = 1'b1;
                n1 = 1'b0;
                pc1 = (o6 == 6'h07);
                imm = {inst[24:5], 12'b0};
            end
            6'h0a: begin
                op = 0;
                ui = 1'b1;
                e.ld = (inst[25:22] == 4'h2);
                e.st = (inst[25:22] == 4'h6);
                if (e.st) begin
                    e.we = 1'b0;
                    r2 = rd;
                    n2 = 1'b1;
                end
            end
            6'h13, 6'h15: begin                      // jirl and bl link pc + 4
                op = 0;
                ui = 1'b1;
                pc1 = 1'b1;
                imm = 32'd4;
                e.tk = 1'b1;
                if (o6 == 6'h15) begin
                    n1 = 1'b0;
                    e.wa = 5'd1;
                    offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
                end
            end
            6'h14: begin
                n1 = 1'b0;
                e.we = 1'b0;
                e.tk = 1'b1;
                offs = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            end
            default: begin                           // conditional branches
                e.we = 1'b0;
                r2 = rd;
                n2 = 1'b1;
            end
        endcase
        v1 = n1 ? fwd_val(rj) : rf_val(rj);
        v2 = n2 ? fwd_val(r2) : rf_val(r2);
        if (op >= 0) e.op[op] = 1'b1;
        e.s1 = pc1 ? pc : v1;
        e.s2 = ui ? imm : v2;
        e.sd = v2;
        case (o6)
            6'h16: e.tk = (v1 == v2);
            6'h17: e.tk = (v1 != v2);
            6'h18: e.tk = ($signed(v1) < $signed(v2));
            6'h19: e.tk = !($signed(v1) < $signed(v2));
            6'h1a: e.tk = (v1 < v2);
            6'h1b: e.tk = !(v1 < v2);
            default: ;
        endcase
        e.tg = (o6 == 6'h13) ? v1 + offs : pc + offs;
        return e;
    endfunction

    task automatic check_op(input string name, input alu_op_t got, input alu_op_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_branch(input logic tk, input word_t tg, input exp_t e);
        check_level("br_taken", tk, e.tk);
        if (e.tk) check_word("br_target", tg, e.tg);
    endtask

    // compares every instruction that EX accepts
    always @(negedge clk) begin
        exp_t e;
        word_t cp;
        if (resetn && issue_valid && ex_allowin) begin
            if (inst_q.size() == 0) begin
                other_errs++;
                $display("Error: unexpected instruction issued at pc %h", issue_pc);
            end else begin
                cp = pc_q.pop_front();
                e = expect_issue(inst_q.pop_front(), cp);
                check_op("issue_alu_op", issue_alu_op, e.op);
                check_word("issue_src1", issue_src1, e.s1);
                check_word("issue_src2", issue_src2, e.s2);
                if (e.st) check_word("issue_store_data", issue_store_data, e.sd);
                check_word("issue_pc", issue_pc, cp);
                check_level("issue_rf_we", issue_rf_we, e.we);
                if (e.we) check_addr("issue_rf_waddr", issue_rf_waddr, e.wa);
                check_level("issue_load", issue_load, e.ld);
                check_level("issue_store", issue_store, e.st);
                check_branch(br_taken, br_target, e);
            end
        end
    end

    task tick();
        @(posedge clk);
        #1;
    endtask

    task send(input word_t inst, input word_t pc);
        inst_q.push_back(inst);
        pc_q.push_back(pc);
        fetch_valid = 1'b1;
        fetch_inst = inst;
        fetch_pc = pc;
        @(negedge clk);
        while (!id_allowin) @(negedge clk);
        @(posedge clk);
        #1;
        fetch_valid = 1'b0;
    endtask

    task drain();
        while (inst_q.size() != 0) @(posedge clk);
        #1;
    endtask

    task send_rand(input word_t inst);
        word_t p;
        p = rnd();
        send(inst, {p[31:2], 2'b00});
        drain();
    endtask

    initial begin
        logic [4:0] r3[0:10];
        logic [4:0] sh[0:2];
        logic [3:0] i4[0:5];
        logic [5:0] bo[0:8];
        word_t t;
        reg_addr_t ra;
        exp_t held;
        r3 = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09, 5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
        sh = '{5'h01, 5'h09, 5'h11};
        i4 = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
        bo = '{6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b, 6'h14, 6'h15, 6'h13};
        {resetn, fetch_valid, ex_allowin, ex_rf_we, ex_res_late} = '0;
        {mem_rf_we, mem_res_late, wb_rf_we} = '0;
        {fetch_inst, fetch_pc, ex_rf_wdata, mem_rf_wdata, wb_rf_wdata} = '0;
        {ex_rf_waddr, mem_rf_waddr, wb_rf_waddr} = '0;
        mreg[0] = '0;
        repeat (5) tick();
        resetn = 1'b1;
        ex_allowin = 1'b1;
        @(negedge clk);
        check_level("issue_valid", issue_valid, 1'b0);
        check_level("br_taken", br_taken, 1'b0);
        check_level("br_stall", br_stall, 1'b0);
        check_level("id_allowin", id_allowin, 1'b1);
        for (int i = 1; i < 32; i++) begin           // fill through the WB port
            tick();
            wb_rf_we = 1'b1;
            wb_rf_waddr = reg_addr_t'(i);
            wb_rf_wdata = rnd();
            mreg[i] = wb_rf_wdata;
        end
        tick();
        wb_rf_we = 1'b0;

        foreach (r3[i]) send_rand({6'h00, 4'h0, 2'h1, r3[i], rreg(), rreg(), rreg()});
        foreach (sh[i]) send_rand({6'h00, 4'h1, 2'h0, sh[i], rreg(), rreg(), rreg()});
        foreach (i4[i]) begin
            t = rnd();
            send_rand({6'h00, i4[i], t[11:0], rreg(), rreg()});
        end
        t = rnd();
        send_rand({6'h05, 1'b0, t[19:0], rreg()});
        send_rand({6'h07, 1'b0, t[31:12], rreg()});

        for (int i = 0; i < 4; i++) begin            // ld.w and st.w
            t = rnd();
            send_rand({6'h0a, (i[0] ? 4'h6 : 4'h2), t[11:0], rreg(), rreg()});
        end

        for (int i = 0; i < 18; i++) begin           // second pass compares rj with itself
            t = rnd();
            ra = rreg();
            send_rand({bo[i % 9], t[15:0], ra, (i >= 9) ? ra : t[20:16]});
        end

        send({6'h16, 16'h0010, 5'd0, 5'd0}, 32'h0000_1000);   // beq r0, r0 always taken
        fetch_valid = 1'b1;
        fetch_inst = {6'h00, 4'h0, 2'h1, 5'h00, 5'd2, 5'd3, 5'd4};
        fetch_pc = 32'h0000_1004;
        tick();
        fetch_valid = 1'b0;
        repeat (4) tick();

        ex_rf_we = 1'b1;                             // forwarding priority on r5
        mem_rf_we = 1'b1;
        wb_rf_we = 1'b1;
        {ex_rf_waddr, mem_rf_waddr, wb_rf_waddr} = {5'd5, 5'd5, 5'd5};
        ex_rf_wdata = rnd();
        mem_rf_wdata = rnd();
        wb_rf_wdata = rnd();
        send_rand({6'h00, 4'h0, 2'h1, 5'h00, 5'd5, 5'd5, 5'd3});
        ex_rf_we = 1'b0;
        send_rand({6'h00, 4'h0, 2'h1, 5'h00, 5'd5, 5'd5, 5'd3});
        {mem_rf_waddr, wb_rf_waddr} = {5'd0, 5'd0};
        send_rand({6'h00, 4'h0, 2'h1, 5'h00, 5'd0, 5'd0, 5'd3});
        {mem_rf_we, wb_rf_we} = '0;
        mreg[5] = wb_rf_wdata;                       // WB wrote r5 while it was active

        for (int i = 0; i < 2; i++) begin            // late result on r7, then a branch
            ex_rf_we = (i == 0);
            ex_res_late = (i == 0);
            mem_rf_we = (i == 1);
            mem_res_late = (i == 1);
            {ex_rf_waddr, mem_rf_waddr} = {5'd7, 5'd7};
            ex_rf_wdata = rnd();
            mem_rf_wdata = rnd();
            send(i == 0 ? {6'h00, 4'h0, 2'h1, 5'h00, 5'd2, 5'd7, 5'd3}
                        : {6'h16, 16'h0004, 5'd7, 5'd8}, 32'h0000_2000);
            repeat (4) begin
                @(negedge clk);
                check_level("issue_valid", issue_valid, 1'b0);
                check_level("id_allowin", id_allowin, 1'b0);
                check_level("br_taken", br_taken, 1'b0);
                check_level("br_stall", br_stall, i == 1);
            end
            tick();
            {ex_res_late, mem_res_late} = '0;
            drain();
            {ex_rf_we, mem_rf_we} = '0;
        end

        ex_allowin = 1'b0;                           // back-pressure from EX
        t = {6'h00, 4'h0, 2'h1, 5'h0b, 5'd9, 5'd10, 5'd11};
        held = expect_issue(t, 32'h0000_3000);
        send(t, 32'h0000_3000);
        fetch_valid = 1'b1;                          // a younger one waits at fetch
        fetch_inst = {6'h00, 4'h0, 2'h1, 5'h00, 5'd2, 5'd3, 5'd4};
        fetch_pc = 32'h0000_3004;
        repeat (5) begin
            @(negedge clk);
            check_level("id_allowin", id_allowin, 1'b0);
            check_level("issue_valid", issue_valid, 1'b1);
            check_op("issue_alu_op", issue_alu_op, held.op);
            check_word("issue_src1", issue_src1, held.s1);
            check_word("issue_src2", issue_src2, held.s2);
            check_word("issue_pc", issue_pc, 32'h0000_3000);
            check_addr("issue_rf_waddr", issue_rf_waddr, held.wa);
        end
        tick();
        fetch_valid = 1'b0;
        ex_allowin = 1'b1;
        drain();
        repeat (3) tick();

        if (inst_q.size() != 0) begin
            other_errs++;
            $display("Error: %0d instructions never issued", inst_q.size());
        end
        $display("errors: %0d mismatches, %0d other", mismatches, other_errs);
        if (mismatches == 0 && other_errs == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
